// File: common/fir_pkg.sv
// ====================
// shared types, register map and tap count for the fir engine
// referenced by scoped names from every design block
// ====================

package fir_pkg;

    // one sample, output value or accumulator, 32-bit unsigned modulo 2^32
    typedef logic [31:0] sample_t;

    // one filter coefficient
    typedef logic [31:0] coef_t;

    // configuration byte address
    typedef logic [11:0] cfg_addr_t;

    // tap index and history slot, 0 to NUM_TAPS-1
    typedef logic [3:0] tap_idx_t;

    localparam int NUM_TAPS = 11;

    // control/status word
    //   bit 0  ap_start, high for the cycle after a start write
    //   bit 1  ap_done, set when the last output transfers, cleared by a status read
    //   bit 2  ap_idle, low from start until the last output transfers
    //   other bits read zero
    localparam cfg_addr_t ADDR_AP_CTRL = 12'h000;

    // number of samples per run
    localparam cfg_addr_t ADDR_DATA_LEN = 12'h010;

    // coefficient k at ADDR_TAP_BASE + 4*k
    localparam cfg_addr_t ADDR_TAP_BASE = 12'h080;

    // byte span of the coefficient window
    localparam cfg_addr_t TAP_SPAN = cfg_addr_t'(4 * NUM_TAPS);

    // accumulator sequencing
    typedef enum logic [1:0] {
        IDLE,
        WAIT_SAMPLE,
        ACCUM,
        HOLD
    } mac_state_t;

endpackage

// File: design/fir_ctrl_regs.sv
// ====================
// configuration registers, coefficient store and status bits
// write and read strobes are single cycle, read data follows one cycle later
// ====================

`timescale 1ns/1ps

module fir_ctrl_regs (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               cfg_we_i,
    input  logic               cfg_re_i,
    input  fir_pkg::cfg_addr_t cfg_addr_i,
    input  fir_pkg::sample_t   cfg_wdata_i,
    output logic               cfg_rvalid_o,
    output fir_pkg::sample_t   cfg_rdata_o,
    input  logic               run_end_i,
    input  fir_pkg::tap_idx_t  tap_idx_i,
    output fir_pkg::coef_t     coef_o,
    output logic               start_o,
    output fir_pkg::sample_t   data_len_o
);

    fir_pkg::coef_t    coef_q [fir_pkg::NUM_TAPS];
    fir_pkg::sample_t  data_len_q;
    fir_pkg::sample_t  rdata_q;
    fir_pkg::sample_t  rd_mux;
    fir_pkg::sample_t  status_word;
    fir_pkg::cfg_addr_t tap_off;
    fir_pkg::tap_idx_t tap_sel;
    logic              tap_hit;
    logic              rvalid_q;
    logic              start_q;
    logic              done_q;
    logic              idle_q;
    logic              start_req;
    logic              status_rd;

    // addresses below the base wrap to a large offset and miss the window
    assign tap_off = cfg_addr_i - fir_pkg::ADDR_TAP_BASE;
    assign tap_sel = tap_off[5:2];
    assign tap_hit = (tap_off < fir_pkg::TAP_SPAN) && (tap_off[1:0] == 2'b00);

    // start only honoured while idle
    assign start_req = cfg_we_i && (cfg_addr_i == fir_pkg::ADDR_AP_CTRL)
                    && cfg_wdata_i[0] && idle_q;
    assign status_rd = cfg_re_i && (cfg_addr_i == fir_pkg::ADDR_AP_CTRL);

    assign status_word = {29'd0, idle_q, done_q, start_q};

    always_comb begin
        rd_mux = '0;
        if (cfg_addr_i == fir_pkg::ADDR_AP_CTRL) begin
            rd_mux = status_word;
        end else if (cfg_addr_i == fir_pkg::ADDR_DATA_LEN) begin
            rd_mux = data_len_q;
        end else if (tap_hit) begin
            rd_mux = coef_q[tap_sel];
        end
    end

    // coefficient store
    always_ff @(posedge axis_clk) begin
        if (cfg_we_i && tap_hit) begin
            coef_q[tap_sel] <= cfg_wdata_i;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (cfg_re_i) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            rvalid_q   <= 1'b0;
            start_q    <= 1'b0;
            done_q     <= 1'b0;
            idle_q     <= 1'b1;
            data_len_q <= '0;
        end else begin
            rvalid_q <= cfg_re_i;
            start_q  <= start_req;
            if (cfg_we_i && (cfg_addr_i == fir_pkg::ADDR_DATA_LEN)) begin
                data_len_q <= cfg_wdata_i;
            end
            if (start_req) begin
                idle_q <= 1'b0;
                done_q <= 1'b0;
            end else if (run_end_i) begin
                idle_q <= 1'b1;
                done_q <= 1'b1;
            end else if (status_rd && done_q) begin
                // done is read-to-clear
                done_q <= 1'b0;
            end
        end
    end

    // engine side coefficient lookup
    assign coef_o = (tap_idx_i < fir_pkg::NUM_TAPS) ? coef_q[tap_idx_i] : '0;

    assign cfg_rvalid_o = rvalid_q;
    assign cfg_rdata_o  = rdata_q;
    assign start_o      = start_q;
    assign data_len_o   = data_len_q;

endmodule

// File: design/fir_top.sv
// ====================
// fir engine top level
// register port, sample history, accumulator and output register in a chain
// ====================

`timescale 1ns/1ps

module fir_top (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               cfg_we_i,
    input  logic               cfg_re_i,
    input  fir_pkg::cfg_addr_t cfg_addr_i,
    input  fir_pkg::sample_t   cfg_wdata_i,
    output logic               cfg_rvalid_o,
    output fir_pkg::sample_t   cfg_rdata_o,
    input  logic               s_valid_i,
    input  fir_pkg::sample_t   s_data_i,
    output logic               s_ready_o,
    output logic               m_valid_o,
    output fir_pkg::sample_t   m_data_o,
    output logic               m_last_o,
    input  logic               m_ready_i
);

    logic              start;
    fir_pkg::sample_t  data_len;
    fir_pkg::tap_idx_t tap_idx;
    fir_pkg::coef_t    coef;
    logic              push;
    fir_pkg::sample_t  push_data;
    fir_pkg::sample_t  hist;
    logic              res_strobe;
    fir_pkg::sample_t  res_data;
    logic              res_last;
    logic              out_full;
    logic              run_end;

    fir_ctrl_regs u_ctrl_regs (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .cfg_we_i     (cfg_we_i),
        .cfg_re_i     (cfg_re_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rvalid_o (cfg_rvalid_o),
        .cfg_rdata_o  (cfg_rdata_o),
        .run_end_i    (run_end),
        .tap_idx_i    (tap_idx),
        .coef_o       (coef),
        .start_o      (start),
        .data_len_o   (data_len)
    );

    fir_sample_hist u_sample_hist (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start_i    (start),
        .push_i     (push),
        .sample_i   (push_data),
        .tap_idx_i  (tap_idx),
        .hist_o     (hist)
    );

    fir_mac u_mac (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start_i      (start),
        .data_len_i   (data_len),
        .s_valid_i    (s_valid_i),
        .s_data_i     (s_data_i),
        .s_ready_o    (s_ready_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .tap_idx_o    (tap_idx),
        .coef_i       (coef),
        .hist_i       (hist),
        .out_full_i   (out_full),
        .res_strobe_o (res_strobe),
        .res_data_o   (res_data),
        .res_last_o   (res_last)
    );

    fir_out_reg u_out_reg (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .res_strobe_i (res_strobe),
        .res_data_i   (res_data),
        .res_last_i   (res_last),
        .full_o       (out_full),
        .m_valid_o    (m_valid_o),
        .m_data_o     (m_data_o),
        .m_last_o     (m_last_o),
        .m_ready_i    (m_ready_i),
        .run_end_o    (run_end)
    );

endmodule

// File: dv/fir_clk_gen.sv
// ====================
// testbench clock, 8 ns period
// reset held low for the first 4 cycles
// ====================

`timescale 1ns/1ps

module fir_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        // release on a falling edge, clear of the active edge
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: dv/fir_props.sv
// ====================
// stream and latency assertions for the fir engine
// attached to the top level with bind
// ====================

`timescale 1ns/1ps

module fir_props (
    input logic             axis_clk,
    input logic             axis_rst_n,
    input logic             s_valid_i,
    input logic             s_ready_o,
    input logic             m_valid_o,
    input fir_pkg::sample_t m_data_o,
    input logic             m_last_o,
    input logic             m_ready_i,
    input logic             res_strobe_i
);

    // a stalled result keeps valid, data and last
    out_hold_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o) && $stable(m_last_o))
        else $error("output stream changed while stalled");

    // once the last result is pending the run takes no more samples
    no_accept_after_last: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        m_valid_o && m_last_o |-> !s_ready_o)
        else $error("input ready while the last result is pending");

    // valid rises 13 edges after an accept into an empty output register
    // the rise shows in the sampled values one edge later
    empty_latency: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        s_valid_i && s_ready_o && !m_valid_o && !res_strobe_i |-> ##14 $rose(m_valid_o))
        else $error("output latency differs from 13 cycles");

endmodule

bind fir_top fir_props u_props (
    .axis_clk     (axis_clk),
    .axis_rst_n   (axis_rst_n),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .m_valid_o    (m_valid_o),
    .m_data_o     (m_data_o),
    .m_last_o     (m_last_o),
    .m_ready_i    (m_ready_i),
    .res_strobe_i (res_strobe)
);

// File: dv/fir_tb.sv
// ====================
// fir engine testbench, runs a table of filter jobs through the DUT
// checks register read-back, status, outputs against a reference model
// ====================

`timescale 1ns/1ps

module fir_tb;

    localparam int NUM_TESTS = 5;
    // per run: sample count, impulse coefficients, random output back-pressure
    localparam int LEN_TAB     [NUM_TESTS] = '{8, 24, 6, 1, 16};
    localparam bit IMPULSE_TAB [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    localparam bit BP_TAB      [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    localparam int CYCLES_PER_SAMPLE = 40;
    localparam int MARGIN_CYCLES     = 1500;

    logic               axis_clk;
    logic               axis_rst_n;
    logic               cfg_we_i;
    logic               cfg_re_i;
    fir_pkg::cfg_addr_t cfg_addr_i;
    fir_pkg::sample_t   cfg_wdata_i;
    logic               cfg_rvalid_o;
    fir_pkg::sample_t   cfg_rdata_o;
    logic               s_valid_i;
    fir_pkg::sample_t   s_data_i;
    logic               s_ready_o;
    logic               m_valid_o;
    fir_pkg::sample_t   m_data_o;
    logic               m_last_o;
    logic               m_ready_i;

    fir_pkg::coef_t     coefs [fir_pkg::NUM_TAPS];
    fir_pkg::sample_t   samples [$];
    fir_pkg::sample_t   expected [$];
    int                 err_count;
    int                 check_count;

    fir_clk_gen u_clk_gen (
        .clk_o   (axis_clk),
        .rst_n_o (axis_rst_n)
    );

    fir_top u_fir_top (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .cfg_we_i     (cfg_we_i),
        .cfg_re_i     (cfg_re_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .cfg_rvalid_o (cfg_rvalid_o),
        .cfg_rdata_o  (cfg_rdata_o),
        .s_valid_i    (s_valid_i),
        .s_data_i     (s_data_i),
        .s_ready_o    (s_ready_o),
        .m_valid_o    (m_valid_o),
        .m_data_o     (m_data_o),
        .m_last_o     (m_last_o),
        .m_ready_i    (m_ready_i)
    );

    task automatic check_data(input string name, input fir_pkg::sample_t got,
                              input fir_pkg::sample_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_status(input fir_pkg::sample_t got, input fir_pkg::sample_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: status cfg_rdata_o got 0x%08h expected 0x%08h", got, exp);
        end
    endtask

    // status layout: bit 2 idle, bit 1 done, bit 0 start
    function automatic fir_pkg::sample_t make_status(input bit idle, input bit done,
                                                     input bit start);
        return {29'd0, idle, done, start};
    endfunction

    // y[n] = sum of h[k] * x[n-k], history before the run is zero
    function automatic fir_pkg::sample_t fir_model(input int n);
        fir_pkg::sample_t acc;
        acc = '0;
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                acc = acc + coefs[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    task automatic cfg_write(input fir_pkg::cfg_addr_t addr, input fir_pkg::sample_t data);
        @(negedge axis_clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge axis_clk);
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_read(input fir_pkg::cfg_addr_t addr, output fir_pkg::sample_t data);
        @(negedge axis_clk);
        cfg_re_i   = 1'b1;
        cfg_addr_i = addr;
        @(negedge axis_clk);
        cfg_re_i = 1'b0;
        check_count++;
        if (cfg_rvalid_o !== 1'b1) begin
            err_count++;
            $display("read of address 0x%03h gave no valid strobe one cycle later", addr);
        end
        data = cfg_rdata_o;
    endtask

    task automatic feed_samples(input int len);
        for (int i = 0; i < len; i++) begin
            s_valid_i = 1'b1;
            s_data_i  = samples[i];
            while (s_ready_o !== 1'b1) begin
                @(negedge axis_clk);
            end
            // transfer happens on the coming rising edge
            @(negedge axis_clk);
        end
        s_valid_i = 1'b0;
    endtask

    task automatic drain_results(input int len, input bit rand_ready);
        int idx;
        idx = 0;
        while (idx < len) begin
            @(negedge axis_clk);
            m_ready_i = rand_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
            if (m_valid_o && m_ready_i) begin
                check_data("m_data_o", m_data_o, expected[idx]);
                check_flag("m_last_o", m_last_o, idx == len - 1);
                idx++;
            end
        end
    endtask

    task automatic run_test(input int t);
        fir_pkg::sample_t   rd;
        fir_pkg::cfg_addr_t addr;
        int                 len;
        len = LEN_TAB[t];
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            coefs[k] = (IMPULSE_TAB[t] && k != 0) ? '0 : $urandom;
        end
        samples.delete();
        expected.delete();
        for (int n = 0; n < len; n++) begin
            samples.push_back($urandom);
        end
        for (int n = 0; n < len; n++) begin
            expected.push_back(fir_model(n));
        end
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            addr = fir_pkg::ADDR_TAP_BASE + fir_pkg::cfg_addr_t'(4 * k);
            cfg_write(addr, coefs[k]);
        end
        cfg_write(fir_pkg::ADDR_DATA_LEN, fir_pkg::sample_t'(len));
        for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
            addr = fir_pkg::ADDR_TAP_BASE + fir_pkg::cfg_addr_t'(4 * k);
            cfg_read(addr, rd);
            check_data($sformatf("cfg_rdata_o coef %0d", k), rd, coefs[k]);
        end
        cfg_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_data("cfg_rdata_o data_len", rd, fir_pkg::sample_t'(len));
        cfg_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_status(rd, make_status(1'b1, 1'b0, 1'b0));
        cfg_write(fir_pkg::ADDR_AP_CTRL, 32'h1);
        // start pulse already over, engine busy
        cfg_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_status(rd, make_status(1'b0, 1'b0, 1'b0));
        fork
            feed_samples(len);
            drain_results(len, BP_TAB[t]);
        join
        cfg_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_status(rd, make_status(1'b1, 1'b1, 1'b0));
        // done clears on the read that saw it
        cfg_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_status(rd, make_status(1'b1, 1'b0, 1'b0));
    endtask

    initial begin
        int limit;
        limit = MARGIN_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += CYCLES_PER_SAMPLE * LEN_TAB[t];
        end
        repeat (limit) @(posedge axis_clk);
        $display("timeout: run still busy after %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int errs_before;
        int passed;
        cfg_we_i    = 1'b0;
        cfg_re_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        s_valid_i   = 1'b0;
        s_data_i    = '0;
        m_ready_i   = 1'b0;
        err_count   = 0;
        check_count = 0;
        passed      = 0;
        void'($urandom(49589));
        wait (axis_rst_n == 1'b1);
        @(negedge axis_clk);
        check_flag("s_ready_o", s_ready_o, 1'b0);
        check_flag("m_valid_o", m_valid_o, 1'b0);
        check_flag("cfg_rvalid_o", cfg_rvalid_o, 1'b0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_count;
            run_test(t);
            if (err_count == errs_before) begin
                passed++;
            end
            $display("test %0d len %0d coef %s ready %s: %s", t, LEN_TAB[t],
                     IMPULSE_TAB[t] ? "impulse" : "random",
                     BP_TAB[t] ? "random" : "always",
                     (err_count == errs_before) ? "ok" : "mismatch");
        end
        $display("tests %0d passed %0d failed %0d checks %0d errors %0d", NUM_TESTS,
                 passed, NUM_TESTS - passed, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: fir_core/fir_mac.sv
// ====================
// sample acceptance and sequential multiply-accumulate over NUM_TAPS taps
// one result per accepted sample, handed to the output register as a strobe
// ====================

`timescale 1ns/1ps

module fir_mac (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              start_i,
    input  fir_pkg::sample_t  data_len_i,
    input  logic              s_valid_i,
    input  fir_pkg::sample_t  s_data_i,
    output logic              s_ready_o,
    output logic              push_o,
    output fir_pkg::sample_t  push_data_o,
    output fir_pkg::tap_idx_t tap_idx_o,
    input  fir_pkg::coef_t    coef_i,
    input  fir_pkg::sample_t  hist_i,
    input  logic              out_full_i,
    output logic              res_strobe_o,
    output fir_pkg::sample_t  res_data_o,
    output logic              res_last_o
);

    fir_pkg::mac_state_t state_q;
    fir_pkg::sample_t    count_q;
    fir_pkg::sample_t    acc_q;
    fir_pkg::tap_idx_t   tap_q;
    logic                last_q;
    logic                strobe_q;
    logic                accept;

    assign s_ready_o = (state_q == fir_pkg::WAIT_SAMPLE) && (count_q < data_len_i);
    assign accept    = s_valid_i && s_ready_o;

    // accepted sample goes into the history on the same edge
    assign push_o      = accept;
    assign push_data_o = s_data_i;
    assign tap_idx_o   = tap_q;

    // acc_q and last_q stay put until the next accept, after the strobe
    assign res_strobe_o = strobe_q;
    assign res_data_o   = acc_q;
    assign res_last_o   = last_q;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state_q  <= fir_pkg::IDLE;
            count_q  <= '0;
            tap_q    <= '0;
            last_q   <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state_q)
                fir_pkg::IDLE: begin
                    if (start_i) begin
                        count_q <= '0;
                        // zero length run makes no output
                        state_q <= (data_len_i == '0) ? fir_pkg::IDLE : fir_pkg::WAIT_SAMPLE;
                    end
                end
                fir_pkg::WAIT_SAMPLE: begin
                    if (accept) begin
                        count_q <= count_q + 32'd1;
                        last_q  <= ((count_q + 32'd1) == data_len_i);
                        tap_q   <= '0;
                        state_q <= fir_pkg::ACCUM;
                    end
                end
                fir_pkg::ACCUM: begin
                    tap_q <= tap_q + 4'd1;
                    if (tap_q == fir_pkg::tap_idx_t'(fir_pkg::NUM_TAPS - 1)) begin
                        state_q <= fir_pkg::HOLD;
                    end
                end
                fir_pkg::HOLD: begin
                    // wait for the output register to drain
                    if (!out_full_i) begin
                        strobe_q <= 1'b1;
                        state_q  <= last_q ? fir_pkg::IDLE : fir_pkg::WAIT_SAMPLE;
                    end
                end
                default: begin
                    state_q <= fir_pkg::IDLE;
                end
            endcase
        end
    end

    // one tap per cycle, products and sums wrap at 32 bits
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc_q <= '0;
        end else if (state_q == fir_pkg::ACCUM) begin
            acc_q <= acc_q + coef_i * hist_i;
        end
    end

endmodule

// File: fir_core/fir_out_reg.sv
// ====================
// one-entry output register on the result stream
// holds valid, data and last until the consumer takes them
// ====================

`timescale 1ns/1ps

module fir_out_reg (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             res_strobe_i,
    input  fir_pkg::sample_t res_data_i,
    input  logic             res_last_i,
    output logic             full_o,
    output logic             m_valid_o,
    output fir_pkg::sample_t m_data_o,
    output logic             m_last_o,
    input  logic             m_ready_i,
    output logic             run_end_o
);

    fir_pkg::sample_t data_q;
    logic             valid_q;
    logic             last_q;
    logic             xfer;

    assign xfer = valid_q && m_ready_i;

    always_ff @(posedge axis_clk) begin
        if (res_strobe_i) begin
            data_q <= res_data_i;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (res_strobe_i) begin
            valid_q <= 1'b1;
            last_q  <= res_last_i;
        end else if (xfer) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    assign full_o    = valid_q;
    assign m_valid_o = valid_q;
    assign m_data_o  = data_q;
    assign m_last_o  = last_q;

    // end of run marks the transfer of the last result
    assign run_end_o = xfer && last_q;

endmodule

// File: fir_core/fir_sample_hist.sv
// ====================
// circular history of the last NUM_TAPS input samples
// slots not yet written since start read back as zero
// ====================

`timescale 1ns/1ps

module fir_sample_hist (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              start_i,
    input  logic              push_i,
    input  fir_pkg::sample_t  sample_i,
    input  fir_pkg::tap_idx_t tap_idx_i,
    output fir_pkg::sample_t  hist_o
);

    fir_pkg::sample_t  hist_q [fir_pkg::NUM_TAPS];
    fir_pkg::tap_idx_t wr_ptr_q;
    fir_pkg::tap_idx_t fill_q;
    fir_pkg::tap_idx_t rd_ptr;
    logic [4:0]        rd_sum;

    // newest sample sits at wr_ptr-1, step back tap_idx slots modulo NUM_TAPS
    assign rd_sum = 5'(wr_ptr_q) + 5'(fir_pkg::NUM_TAPS - 1) - 5'(tap_idx_i);
    assign rd_ptr = (rd_sum >= 5'(fir_pkg::NUM_TAPS))
                  ? fir_pkg::tap_idx_t'(rd_sum - 5'(fir_pkg::NUM_TAPS))
                  : fir_pkg::tap_idx_t'(rd_sum);

    // mask samples older than the start of the run
    assign hist_o = (tap_idx_i < fill_q) ? hist_q[rd_ptr] : '0;

    always_ff @(posedge axis_clk) begin
        if (push_i) begin
            hist_q[wr_ptr_q] <= sample_i;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_ptr_q <= '0;
            fill_q   <= '0;
        end else if (start_i) begin
            wr_ptr_q <= '0;
            fill_q   <= '0;
        end else if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == fir_pkg::tap_idx_t'(fir_pkg::NUM_TAPS - 1))
                      ? '0 : wr_ptr_q + 4'd1;
            // saturates once the history is full
            if (fill_q < fir_pkg::tap_idx_t'(fir_pkg::NUM_TAPS)) begin
                fill_q <= fill_q + 4'd1;
            end
        end
    end

endmodule

// File: fir_top.f
common/fir_pkg.sv
design/fir_ctrl_regs.sv
fir_core/fir_sample_hist.sv
fir_core/fir_mac.sv
fir_core/fir_out_reg.sv
design/fir_top.sv
dv/fir_clk_gen.sv
dv/fir_props.sv
dv/fir_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fir testbench with verilator, run it, and look for the pass marker in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f fir_top.f -o fir_sim \
    && ./obj_dir/fir_sim > "$LOG" 2>&1 \
    || echo "build or simulation ended with an error"
cat "$LOG" 2>/dev/null
grep -qF '** PASS **' "$LOG" && echo "result: passed" && exit 0 \
    || { echo "result: failed"; exit 1; }
